/* bench/datapath_tb.sv */
`timescale 1ns/100ps

module datapath_tb;
    import datapath_pkg::*;

    localparam int RESET_TIMEOUT = 50;
    localparam int MEM_CASES     = 6;

    logic               clk;
    logic               arst_n;
    logic [NUM_GPR-1:0] r_drive;
    logic [NUM_GPR-1:0] r_load;
    logic hi_drive, lo_drive, z_high_drive, z_low_drive, pc_drive, mdr_drive;
    logic in_port_drive, c_drive, ba_select, hi_load, lo_load, y_load, z_load;
    logic pc_load, pc_inc, ir_load, con_load, mar_load, mdr_load, mem_read, mem_write;
    logic out_port_load;
    logic con_flag;
    alu_op_e opcode;
    word_t   in_port;
    word_t   bus;
    word_t   out_port;
    integer  seed;
    word_t   model_gpr [NUM_GPR];
    word_t   model_mem [RAM_DEPTH];

    datapath UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s expected %b, got %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic clear_strobes();
        r_drive = '0;
        r_load = '0;
        {hi_drive, lo_drive, z_high_drive, z_low_drive, pc_drive, mdr_drive} = '0;
        {in_port_drive, c_drive, ba_select, hi_load, lo_load, y_load, z_load} = '0;
        {pc_load, pc_inc, ir_load, con_load, mar_load, mdr_load, mem_read, mem_write} = '0;
        out_port_load = 1'b0;
        opcode = op_add;
    endtask

    // One clock edge, back at the falling edge with strobes cleared
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        clear_strobes();
    endtask

    // Value reaches in_port_q, then in_port_q is put on the bus
    task automatic from_port(input word_t value);
        in_port = value;
        next_cycle();
        in_port_drive = 1'b1;
    endtask

    task automatic load_gpr(input int idx, input word_t value);
        from_port(value);
        r_load[idx] = 1'b1;
        next_cycle();
        model_gpr[idx] = value;
    endtask

    task automatic read_bus(input string name, input word_t expected);
        #2;
        check_word(name, expected, bus);
        next_cycle();
    endtask

    function automatic dword_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0]  sh;
        logic [63:0] rot_r;
        logic [63:0] rot_l;
        longint      sa;
        longint      sb;
        sh = b[4:0];
        rot_r = {a, a} >> sh;
        rot_l = {a, a} << sh;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            op_add:  return {32'h0, a + b};
            op_sub:  return {32'h0, a - b};
            op_and:  return {32'h0, a & b};
            op_or:   return {32'h0, a | b};
            op_shr:  return {32'h0, a >> sh};
            op_shra: return {32'h0, word_t'(sa >>> sh)};
            op_shl:  return {32'h0, a << sh};
            op_ror:  return {32'h0, rot_r[31:0]};
            op_rol:  return {32'h0, rot_l[63:32]};
            op_mul:  return dword_t'(sa * sb);
            op_div: begin
                if (b == 32'h0) begin
                    return {a, 32'hffff_ffff};
                end
                return {word_t'(sa % sb), word_t'(sa / sb)};
            end
            op_neg:  return {32'h0, 32'h0 - b};
            op_not:  return {32'h0, ~b};
            default: return '0;
        endcase
    endfunction

    function automatic logic con_ref(input con_e cond, input word_t v);
        case (cond)
            con_zero:     return v == 32'h0;
            con_nonzero:  return v != 32'h0;
            con_positive: return !v[31] && v != 32'h0;
            default:      return v[31];
        endcase
    endfunction

    initial begin : stimulus
        word_t   a;
        word_t   b;
        word_t   v;
        dword_t  expected;
        alu_op_e cur_op;
        con_e    cur_con;
        int      waited;
        word_t   addr_word [MEM_CASES];
        seed = 32'h2470_b90e;
        in_port = '0;
        clear_strobes();
        waited = 0;
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            abort_run("Timeout: reset was never released");
        end
        check_word("out_port after reset", '0, out_port);
        check_flag("con_flag after reset", 1'b0, con_flag);

        // Register transfer
        for (int k = 0; k < NUM_GPR; k++) begin
            load_gpr(k, $random(seed));
        end
        a = $random(seed);
        from_port(a);
        hi_load = 1'b1;
        next_cycle();
        b = $random(seed);
        from_port(b);
        lo_load = 1'b1;
        next_cycle();
        for (int k = 1; k < NUM_GPR; k++) begin
            r_drive[k] = 1'b1;
            read_bus($sformatf("bus from R%0d", k), model_gpr[k]);
        end
        hi_drive = 1'b1;
        read_bus("bus from HI", a);
        lo_drive = 1'b1;
        read_bus("bus from LO", b);
        r_drive[0] = 1'b1;
        ba_select = 1'b1;
        read_bus("bus from R0 with ba_select", '0);
        r_drive[0] = 1'b1;
        read_bus("bus from R0", model_gpr[0]);

        // ALU, last pass is a divide by zero
        for (int n = 0; n <= 13; n++) begin
            cur_op = (n == 13) ? op_div : alu_op_e'(n[4:0]);
            a = $random(seed);
            b = (n == 13) ? 32'h0 : $random(seed);
            load_gpr(1, a);
            load_gpr(2, b);
            r_drive[1] = 1'b1;
            y_load = 1'b1;
            next_cycle();
            r_drive[2] = 1'b1;
            opcode = cur_op;
            z_load = 1'b1;
            next_cycle();
            expected = alu_ref(cur_op, a, b);
            z_low_drive = 1'b1;
            read_bus($sformatf("z_low for %s", cur_op.name()), expected[31:0]);
            z_high_drive = 1'b1;
            read_bus($sformatf("z_high for %s", cur_op.name()), expected[63:32]);
        end

        // Memory write, then read back; MAR keeps only the low address bits
        for (int n = 0; n < MEM_CASES; n++) begin
            addr_word[n] = $random(seed);
            v = $random(seed);
            from_port(addr_word[n]);
            mar_load = 1'b1;
            next_cycle();
            from_port(v);
            mdr_load = 1'b1;
            next_cycle();
            mem_write = 1'b1;
            next_cycle();
            model_mem[addr_word[n][ADDR_W-1:0]] = v;
        end
        for (int n = 0; n < MEM_CASES; n++) begin
            from_port(addr_word[n]);
            mar_load = 1'b1;
            next_cycle();
            mem_read = 1'b1;
            mdr_load = 1'b1;
            next_cycle();
            mdr_drive = 1'b1;
            read_bus($sformatf("MDR from RAM[%0d]", addr_word[n][ADDR_W-1:0]),
                     model_mem[addr_word[n][ADDR_W-1:0]]);
        end

        // PC stepping and load priority
        v = $random(seed);
        from_port(v);
        pc_load = 1'b1;
        next_cycle();
        for (int n = 1; n <= 3; n++) begin
            pc_inc = 1'b1;
            next_cycle();
            pc_drive = 1'b1;
            read_bus("bus from PC", v + word_t'(n));
        end
        a = $random(seed);
        from_port(a);
        pc_load = 1'b1;
        pc_inc = 1'b1;
        next_cycle();
        pc_drive = 1'b1;
        read_bus("bus from PC after load with inc", a);

        // Immediate with both signs of bit 18
        for (int n = 0; n < 4; n++) begin
            v = $random(seed);
            v[18] = n[0];
            from_port(v);
            ir_load = 1'b1;
            next_cycle();
            c_drive = 1'b1;
            read_bus("bus from IR immediate", {{13{v[18]}}, v[18:0]});
        end

        // CON for every condition: zero, positive, negative, random bus value
        for (int c = 0; c < 4; c++) begin
            cur_con = con_e'(c[1:0]);
            for (int n = 0; n < 4; n++) begin
                v = $random(seed);
                v[20:19] = c[1:0];
                from_port(v);
                ir_load = 1'b1;
                next_cycle();
                b = $random(seed);
                if (n == 0) begin
                    b = 32'h0;
                end else if (n == 1) begin
                    b[31] = 1'b0;
                end else if (n == 2) begin
                    b[31] = 1'b1;
                end
                from_port(b);
                con_load = 1'b1;
                next_cycle();
                check_flag($sformatf("con_flag for %s, bus %h", cur_con.name(), b),
                           con_ref(cur_con, b), con_flag);
            end
        end

        v = $random(seed);
        from_port(v);
        out_port_load = 1'b1;
        next_cycle();
        check_word("out_port", v, out_port);
        from_port($random(seed));
        next_cycle();
        check_word("out_port without load", v, out_port);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* files.f */
src/datapath_pkg.sv
src/mem_if.sv
src/register_file.sv
src/bus_mux.sv
src/alu_unit.sv
src/program_regs.sv
src/memory_io.sv
src/ram.sv
src/datapath.sv
bench/datapath_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module datapath_tb

# A failing run still prints its output before the search
output=$(./obj_dir/Vdatapath_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* src/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  datapath_pkg::word_t    bus,
    input  datapath_pkg::alu_op_e  opcode,
    input  logic                   y_load,
    input  logic                   z_load,
    output datapath_pkg::word_t    z_high,
    output datapath_pkg::word_t    z_low
);
    import datapath_pkg::*;

    word_t                      y_q;
    dword_t                     z_q;
    dword_t                     alu_result;
    logic [4:0]                 shamt;
    logic signed [2*WORD_W-1:0] a_ext;
    logic signed [2*WORD_W-1:0] b_ext;
    dword_t                     product;
    word_t                      quotient;
    word_t                      remainder;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y_q <= '0;
        end else if (y_load) begin
            y_q <= bus;
        end
    end

    assign shamt = bus[4:0];

    // Signed 64-bit product
    assign a_ext   = {{WORD_W{y_q[WORD_W-1]}}, y_q};
    assign b_ext   = {{WORD_W{bus[WORD_W-1]}}, bus};
    assign product = a_ext * b_ext;

    assign quotient  = word_t'($signed(y_q) / $signed(bus));
    assign remainder = word_t'($signed(y_q) % $signed(bus));

    // A is Y, B is the bus
    always_comb begin
        alu_result = '0;
        case (opcode)
            op_add:  alu_result[WORD_W-1:0] = y_q + bus;
            op_sub:  alu_result[WORD_W-1:0] = y_q - bus;
            op_and:  alu_result[WORD_W-1:0] = y_q & bus;
            op_or:   alu_result[WORD_W-1:0] = y_q | bus;
            op_shr:  alu_result[WORD_W-1:0] = y_q >> shamt;
            op_shra: alu_result[WORD_W-1:0] = word_t'($signed(y_q) >>> shamt);
            op_shl:  alu_result[WORD_W-1:0] = y_q << shamt;
            op_ror:  alu_result[WORD_W-1:0] = (y_q >> shamt) | (y_q << (6'd32 - shamt));
            op_rol:  alu_result[WORD_W-1:0] = (y_q << shamt) | (y_q >> (6'd32 - shamt));
            op_mul:  alu_result = product;
            op_div: begin
                if (bus == '0) begin
                    // Divide by zero flags all ones, keeps dividend
                    alu_result = {y_q, {WORD_W{1'b1}}};
                end else begin
                    alu_result = {remainder, quotient};
                end
            end
            op_neg:  alu_result[WORD_W-1:0] = -bus;
            op_not:  alu_result[WORD_W-1:0] = ~bus;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            z_q <= '0;
        end else if (z_load) begin
            z_q <= alu_result;
        end
    end

    assign z_high = z_q[2*WORD_W-1:WORD_W];
    assign z_low  = z_q[WORD_W-1:0];

endmodule

/* src/bus_mux.sv */
`timescale 1ns/100ps

module bus_mux (
    input  datapath_pkg::word_t               gpr [datapath_pkg::NUM_GPR],
    input  datapath_pkg::word_t               hi,
    input  datapath_pkg::word_t               lo,
    input  datapath_pkg::word_t               z_high,
    input  datapath_pkg::word_t               z_low,
    input  datapath_pkg::word_t               pc,
    input  datapath_pkg::word_t               mdr,
    input  datapath_pkg::word_t               in_port_q,
    input  datapath_pkg::word_t               ir,
    input  logic [datapath_pkg::NUM_GPR-1:0]  r_drive,
    input  logic                              hi_drive,
    input  logic                              lo_drive,
    input  logic                              z_high_drive,
    input  logic                              z_low_drive,
    input  logic                              pc_drive,
    input  logic                              mdr_drive,
    input  logic                              in_port_drive,
    input  logic                              c_drive,
    input  logic                              ba_select,
    output datapath_pkg::word_t               bus
);
    import datapath_pkg::*;

    logic [NUM_BUS_SRC-1:0] drive_vec;
    bus_src_e               src;
    logic                   src_valid;
    word_t                  c_imm;

    assign drive_vec = {c_drive, in_port_drive, mdr_drive, pc_drive,
                        z_low_drive, z_high_drive, lo_drive, hi_drive, r_drive};

    assign c_imm = {{(WORD_W-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

    // Encoder
    always_comb begin
        src       = src_r0;
        src_valid = 1'b0;
        for (int i = 0; i < NUM_BUS_SRC; i++) begin
            if (drive_vec[i]) begin
                src       = bus_src_e'(i[4:0]);
                src_valid = 1'b1;
            end
        end
    end

    always_comb begin
        bus = '0;
        if (src_valid) begin
            case (src)
                src_hi:     bus = hi;
                src_lo:     bus = lo;
                src_zhigh:  bus = z_high;
                src_zlow:   bus = z_low;
                src_pc:     bus = pc;
                src_mdr:    bus = mdr;
                src_inport: bus = in_port_q;
                src_cimm:   bus = c_imm;
                default:    bus = gpr[src[3:0]];
            endcase
            // R0 as base address reads zero
            if (src == src_r0 && ba_select) begin
                bus = '0;
            end
        end
    end

    always_comb begin
        assert final ($onehot0(drive_vec))
            else $error("bus_mux: more than one drive strobe high");
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [datapath_pkg::NUM_GPR-1:0]  r_drive,
    input  logic                              hi_drive,
    input  logic                              lo_drive,
    input  logic                              z_high_drive,
    input  logic                              z_low_drive,
    input  logic                              pc_drive,
    input  logic                              mdr_drive,
    input  logic                              in_port_drive,
    input  logic                              c_drive,
    input  logic                              ba_select,
    input  logic [datapath_pkg::NUM_GPR-1:0]  r_load,
    input  logic                              hi_load,
    input  logic                              lo_load,
    input  logic                              y_load,
    input  logic                              z_load,
    input  logic                              pc_load,
    input  logic                              pc_inc,
    input  logic                              ir_load,
    input  logic                              con_load,
    input  logic                              mar_load,
    input  logic                              mdr_load,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              out_port_load,
    input  datapath_pkg::alu_op_e             opcode,
    input  datapath_pkg::word_t               in_port,
    output datapath_pkg::word_t               bus,
    output datapath_pkg::word_t               out_port,
    output logic                              con_flag
);
    import datapath_pkg::*;

    word_t gpr [NUM_GPR];
    word_t hi;
    word_t lo;
    word_t z_high;
    word_t z_low;
    word_t pc;
    word_t ir;
    word_t mdr;
    word_t in_port_q;

    mem_if mem_bus ();

    register_file u_register_file (
        .clk, .arst_n, .bus, .r_load, .hi_load, .lo_load, .gpr, .hi, .lo
    );

    bus_mux u_bus_mux (
        .gpr, .hi, .lo, .z_high, .z_low, .pc, .mdr, .in_port_q, .ir,
        .r_drive, .hi_drive, .lo_drive, .z_high_drive, .z_low_drive,
        .pc_drive, .mdr_drive, .in_port_drive, .c_drive, .ba_select, .bus
    );

    alu_unit u_alu_unit (
        .clk, .arst_n, .bus, .opcode, .y_load, .z_load, .z_high, .z_low
    );

    program_regs u_program_regs (
        .clk, .arst_n, .bus, .pc_load, .pc_inc, .ir_load, .con_load, .pc, .ir, .con_flag
    );

    memory_io u_memory_io (
        .clk, .arst_n, .bus, .in_port, .mar_load, .mdr_load, .mem_read, .mem_write,
        .out_port_load, .mem(mem_bus.regs), .mdr, .in_port_q, .out_port
    );

    ram u_ram (
        .clk,
        .mem(mem_bus.mem)
    );

endmodule

/* src/datapath_pkg.sv */
package datapath_pkg;

    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 9;
    localparam int RAM_DEPTH   = 1 << ADDR_W;
    localparam int NUM_GPR     = 16;
    localparam int NUM_BUS_SRC = 24;
    // Immediate field of IR, bits 18:0
    localparam int IMM_W       = 19;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] dword_t;

    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_shr  = 5'd4,
        op_shra = 5'd5,
        op_shl  = 5'd6,
        op_ror  = 5'd7,
        op_rol  = 5'd8,
        op_mul  = 5'd9,
        op_div  = 5'd10,
        op_neg  = 5'd11,
        op_not  = 5'd12
    } alu_op_e;

    // Branch condition from IR bits 20:19
    typedef enum logic [1:0] {
        con_zero     = 2'b00,
        con_nonzero  = 2'b01,
        con_positive = 2'b10,
        con_negative = 2'b11
    } con_e;

    // Bus source index, same order as the drive strobe vector
    typedef enum logic [4:0] {
        src_r0, src_r1, src_r2, src_r3, src_r4, src_r5, src_r6, src_r7,
        src_r8, src_r9, src_r10, src_r11, src_r12, src_r13, src_r14, src_r15,
        src_hi, src_lo, src_zhigh, src_zlow,
        src_pc, src_mdr, src_inport, src_cimm
    } bus_src_e;

endpackage

/* src/mem_if.sv */
`timescale 1ns/100ps

interface mem_if;
    import datapath_pkg::*;

    logic [ADDR_W-1:0] address;
    word_t             write_data;
    logic              write_enable;
    logic              read_enable;
    word_t             read_data;

    modport regs (
        output address, write_data, write_enable, read_enable,
        input  read_data
    );

    modport mem (
        input  address, write_data, write_enable, read_enable,
        output read_data
    );

endinterface

/* src/memory_io.sv */
`timescale 1ns/100ps

module memory_io (
    input  logic                 clk,
    input  logic                 arst_n,
    input  datapath_pkg::word_t  bus,
    input  datapath_pkg::word_t  in_port,
    input  logic                 mar_load,
    input  logic                 mdr_load,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 out_port_load,
    mem_if.regs                  mem,
    output datapath_pkg::word_t  mdr,
    output datapath_pkg::word_t  in_port_q,
    output datapath_pkg::word_t  out_port
);
    import datapath_pkg::*;

    // MAR keeps only the RAM address bits
    logic [ADDR_W-1:0] mar_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar_q <= '0;
        end else if (mar_load) begin
            mar_q <= bus[ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mdr <= '0;
        end else if (mdr_load) begin
            mdr <= mem_read ? mem.read_data : bus;
        end
    end

    assign mem.address      = mar_q;
    assign mem.write_data   = mdr;
    assign mem.write_enable = mem_write;
    assign mem.read_enable  = mem_read;

    // Input port samples every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_port_q <= '0;
        end else begin
            in_port_q <= in_port;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_port <= '0;
        end else if (out_port_load) begin
            out_port <= bus;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(mem_read && mem_write))
        else $error("memory_io: mem_read and mem_write high together");

endmodule

/* src/program_regs.sv */
`timescale 1ns/100ps

module program_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  datapath_pkg::word_t  bus,
    input  logic                 pc_load,
    input  logic                 pc_inc,
    input  logic                 ir_load,
    input  logic                 con_load,
    output datapath_pkg::word_t  pc,
    output datapath_pkg::word_t  ir,
    output logic                 con_flag
);
    import datapath_pkg::*;

    con_e cond;
    logic cond_met;

    // Load wins over increment
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= bus;
        end else if (pc_inc) begin
            pc <= pc + word_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= bus;
        end
    end

    assign cond = con_e'(ir[20:19]);

    always_comb begin
        case (cond)
            con_zero:     cond_met = (bus == '0);
            con_nonzero:  cond_met = (bus != '0);
            con_positive: cond_met = !bus[WORD_W-1] && (bus != '0);
            con_negative: cond_met = bus[WORD_W-1];
            default:      cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            con_flag <= 1'b0;
        end else if (con_load) begin
            con_flag <= cond_met;
        end
    end

endmodule

/* src/ram.sv */
`timescale 1ns/100ps

module ram (
    input logic clk,
    mem_if.mem  mem
);
    import datapath_pkg::*;

    word_t mem_array [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.write_enable) begin
            mem_array[mem.address] <= mem.write_data;
        end
    end

    // Read is asynchronous
    assign mem.read_data = mem_array[mem.address];

    // Never a read and a write in the same cycle
    assert property (@(posedge clk) !(mem.write_enable && mem.read_enable))
        else $error("ram: read_enable and write_enable high together");

endmodule

/* src/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic                                clk,
    input  logic                                arst_n,
    input  datapath_pkg::word_t                 bus,
    input  logic [datapath_pkg::NUM_GPR-1:0]    r_load,
    input  logic                                hi_load,
    input  logic                                lo_load,
    output datapath_pkg::word_t                 gpr [datapath_pkg::NUM_GPR],
    output datapath_pkg::word_t                 hi,
    output datapath_pkg::word_t                 lo
);
    import datapath_pkg::*;

    // General registers R0-R15
    for (genvar i = 0; i < NUM_GPR; i++) begin : g_gpr
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                gpr[i] <= '0;
            end else if (r_load[i]) begin
                gpr[i] <= bus;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
        end else if (hi_load) begin
            hi <= bus;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lo <= '0;
        end else if (lo_load) begin
            lo <= bus;
        end
    end

    // Control unit selects a single destination register per step
    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(r_load))
        else $error("register_file: more than one r_load strobe high");

endmodule
